//--- include/opl_config.svh
`ifndef OPL_CONFIG_SVH
`define OPL_CONFIG_SVH

// voices in the tone generator
`define OPL_NUM_VOICES 4

// clock cycles per audio sample
`define OPL_SAMPLE_DIV 256

// stereo frames held between producer and serializer
`define OPL_FIFO_DEPTH 4

// clock cycles per serial bit
`define OPL_SCLK_DIV 4

`endif

//--- hw/opl_reg_pkg.sv
`include "opl_config.svh"

package opl_reg_pkg;

    // host register map, voice v occupies 4v..4v+3
    typedef enum logic [7:0] {
        REG_VOICE_BASE = 8'h00,
        REG_TIMER1     = 8'h10,
        REG_TIMER2     = 8'h11,
        REG_TIMER_CTRL = 8'h12,
        REG_GLOBAL     = 8'h13,
        REG_STATUS     = 8'h14   // read only
    } reg_addr_e;

    typedef struct packed {
        logic [9:0] fnum;
        logic [2:0] block;
        logic       kon;
        logic [3:0] tl;   // attenuation, 6 dB per step
        logic       cha;  // left
        logic       chb;  // right
    } voice_cfg_t;

    typedef voice_cfg_t [`OPL_NUM_VOICES-1:0] voice_cfg_arr_t;

    typedef struct packed {
        logic [7:0] t1_preload;
        logic [7:0] t2_preload;
        logic       mt1;
        logic       mt2;
        logic       st1;
        logic       st2;
        logic       irq_rst;  // single cycle pulse
    } timer_cfg_t;

endpackage

//--- hw/audio_pkg.sv
package audio_pkg;

    typedef logic signed [15:0] sample_t;

    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    // left sits in the upper half and goes out first
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_frame_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SHIFT
    } i2s_state_e;

endpackage

//--- hw/reg_file.sv
`timescale 1ns/10ps
`include "opl_config.svh"

module reg_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cs,
    input  logic                        rd,
    input  logic                        wr,
    input  opl_reg_pkg::reg_addr_e      address,
    input  logic [7:0]                  data_in,
    input  logic                        ft1,
    input  logic                        ft2,
    input  logic                        irq,
    output logic [7:0]                  data_out,
    output logic                        rd_valid,
    output opl_reg_pkg::voice_cfg_arr_t voice_cfg,
    output opl_reg_pkg::timer_cfg_t     timer_cfg,
    output logic                        enable
);
    import opl_reg_pkg::*;

    localparam int NUM_VREGS = `OPL_NUM_VOICES * 4;

    logic [7:0] voice_regs [NUM_VREGS];
    logic [7:0] timer1_q;
    logic [7:0] timer2_q;
    logic [7:0] ctrl_q;
    logic [7:0] global_q;
    logic       irq_rst_q;
    logic [7:0] rd_data;
    logic       is_voice;
    logic       wr_en;
    logic       rd_en;

    assign wr_en    = cs && wr;
    assign rd_en    = cs && rd;
    assign is_voice = address[7:4] == REG_VOICE_BASE[7:4];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_VREGS; i++) voice_regs[i] <= '0;
            timer1_q  <= '0;
            timer2_q  <= '0;
            ctrl_q    <= '0;
            global_q  <= '0;
            irq_rst_q <= 1'b0;
            rd_valid  <= 1'b0;
            data_out  <= '0;
        end else begin
            irq_rst_q <= 1'b0;  // pulse lasts one cycle
            rd_valid  <= rd_en;
            if (rd_en) data_out <= rd_data;
            if (wr_en) begin
                if (is_voice) begin
                    voice_regs[address[3:0]] <= data_in;
                end else begin
                    case (address)
                        REG_TIMER1:     timer1_q <= data_in;
                        REG_TIMER2:     timer2_q <= data_in;
                        REG_TIMER_CTRL: begin
                            ctrl_q    <= data_in;
                            irq_rst_q <= data_in[7];
                        end
                        REG_GLOBAL:     global_q <= data_in;
                        default:        ;  // status and holes ignore writes
                    endcase
                end
            end
        end
    end

    always_comb begin
        rd_data = 8'h00;
        if (is_voice) begin
            rd_data = voice_regs[address[3:0]];
        end else begin
            case (address)
                REG_TIMER1:     rd_data = timer1_q;
                REG_TIMER2:     rd_data = timer2_q;
                REG_TIMER_CTRL: rd_data = ctrl_q;
                REG_GLOBAL:     rd_data = global_q;
                REG_STATUS:     rd_data = {irq, ft1, ft2, 5'b0};
                default:        rd_data = 8'h00;
            endcase
        end
    end

    // unpack stored bytes into per-voice fields
    always_comb begin
        for (int v = 0; v < `OPL_NUM_VOICES; v++) begin
            voice_cfg[v].fnum  = {voice_regs[4*v+1][1:0], voice_regs[4*v]};
            voice_cfg[v].block = voice_regs[4*v+1][4:2];
            voice_cfg[v].kon   = voice_regs[4*v+1][5];
            voice_cfg[v].tl    = voice_regs[4*v+2][3:0];
            voice_cfg[v].cha   = voice_regs[4*v+3][1];
            voice_cfg[v].chb   = voice_regs[4*v+3][0];
        end
    end

    assign timer_cfg.t1_preload = timer1_q;
    assign timer_cfg.t2_preload = timer2_q;
    assign timer_cfg.mt1        = ctrl_q[6];
    assign timer_cfg.mt2        = ctrl_q[5];
    assign timer_cfg.st1        = ctrl_q[1];
    assign timer_cfg.st2        = ctrl_q[0];
    assign timer_cfg.irq_rst    = irq_rst_q;
    assign enable               = global_q[0];

    // host must never strobe both directions at once
    assert property (@(posedge clk) disable iff (reset) cs |-> !(rd && wr));

endmodule

//--- hw/timers.sv
`timescale 1ns/10ps

module timers (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_tick,
    input  opl_reg_pkg::timer_cfg_t timer_cfg,
    output logic                    ft1,
    output logic                    ft2,
    output logic                    irq
);
    logic [7:0] cnt     [2];
    logic [7:0] preload [2];
    logic [1:0] start;
    logic [1:0] mask;
    logic [1:0] flag;

    assign preload[0] = timer_cfg.t1_preload;
    assign preload[1] = timer_cfg.t2_preload;
    assign start      = {timer_cfg.st2, timer_cfg.st1};
    assign mask       = {timer_cfg.mt2, timer_cfg.mt1};

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
            flag   <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!start[i]) begin
                    cnt[i] <= preload[i];  // hold preload until started
                end else if (sample_tick) begin
                    if (cnt[i] == 8'hff) begin
                        cnt[i]  <= preload[i];
                        flag[i] <= 1'b1;  // sticky until irq_rst
                    end else begin
                        cnt[i] <= cnt[i] + 8'd1;
                    end
                end
            end
            if (timer_cfg.irq_rst) flag <= '0;
        end
    end

    assign ft1 = flag[0];
    assign ft2 = flag[1];
    assign irq = |(flag & ~mask);  // masked flags still show in status

endmodule

//--- hw/tone_gen.sv
`timescale 1ns/10ps
`include "opl_config.svh"

module tone_gen (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        enable,
    input  opl_reg_pkg::voice_cfg_arr_t voice_cfg,
    input  logic                        full,
    output logic                        sample_tick,
    output logic                        push,
    output audio_pkg::stereo_frame_t    frame
);
    import audio_pkg::*;

    localparam int NV    = `OPL_NUM_VOICES;
    localparam int DIV_W = $clog2(`OPL_SAMPLE_DIV);

    logic        [DIV_W-1:0] div_cnt;
    logic        [19:0]      phase      [NV];
    logic        [19:0]      phase_next [NV];
    logic signed [17:0]      voice_val  [NV];
    logic signed [17:0]      sum_l;
    logic signed [17:0]      sum_r;

    function automatic sample_t clamp(input logic signed [17:0] s);
        if (s > SAMPLE_MAX) return SAMPLE_MAX;
        if (s < SAMPLE_MIN) return SAMPLE_MIN;
        return s[15:0];
    endfunction

    // sample tick divider, held at zero while disabled
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= div_cnt == DIV_W'(`OPL_SAMPLE_DIV - 1);
            if (div_cnt == DIV_W'(`OPL_SAMPLE_DIV - 1)) div_cnt <= '0;
            else div_cnt <= div_cnt + 1'b1;
        end
    end

    // mix from the phases as they will be after this tick
    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int v = 0; v < NV; v++) begin
            phase_next[v] = phase[v] + (20'(voice_cfg[v].fnum) << voice_cfg[v].block);
            voice_val[v]  = voice_cfg[v].kon ? 18'(15'h7fff >> voice_cfg[v].tl) : '0;
            if (phase_next[v][19]) voice_val[v] = -voice_val[v];  // low half of square
            if (voice_cfg[v].cha) sum_l = sum_l + voice_val[v];
            if (voice_cfg[v].chb) sum_r = sum_r + voice_val[v];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            for (int v = 0; v < NV; v++) phase[v] <= '0;
        end else if (sample_tick) begin
            for (int v = 0; v < NV; v++) phase[v] <= phase_next[v];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            push  <= 1'b0;
            frame <= '0;
        end else begin
            push <= sample_tick && !full;  // frame dropped when buffer is full
            if (sample_tick) begin
                frame.left  <= clamp(sum_l);
                frame.right <= clamp(sum_r);
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) push |-> $past(sample_tick));

endmodule

//--- hw/frame_fifo.sv
`timescale 1ns/10ps
`include "opl_config.svh"

module frame_fifo (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  audio_pkg::stereo_frame_t frame_in,
    input  logic                     pop,
    output audio_pkg::stereo_frame_t frame_out,
    output logic                     full,
    output logic                     empty
);
    import audio_pkg::*;

    localparam int DEPTH = `OPL_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    stereo_frame_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= frame_in;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
        end
    end

    assign frame_out = mem[rd_ptr];  // head visible before pop
    assign full      = count == (AW+1)'(DEPTH);
    assign empty     = count == '0;

    assert property (@(posedge clk) disable iff (reset) pop |-> !empty);
    assert property (@(posedge clk) disable iff (reset) push |-> !full);

endmodule

//--- hw/i2s_tx.sv
`timescale 1ns/10ps
`include "opl_config.svh"

module i2s_tx (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     empty,
    input  audio_pkg::stereo_frame_t frame,
    output logic                     pop,
    output logic                     sclk,
    output logic                     ws,
    output logic                     sd
);
    import audio_pkg::*;

    localparam int DIV = `OPL_SCLK_DIV;
    localparam int DW  = $clog2(DIV);
    localparam int FW  = $bits(stereo_frame_t);

    i2s_state_e    state;
    logic [DW-1:0] div_cnt;
    logic [4:0]    bit_cnt;
    logic [FW-1:0] shreg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            shreg   <= '0;
        end else begin
            case (state)
                IDLE: if (!empty) state <= LOAD;
                LOAD: begin
                    shreg   <= frame;  // taken with the pop
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= SHIFT;
                end
                SHIFT: begin
                    if (div_cnt == DW'(DIV - 1)) begin
                        div_cnt <= '0;
                        shreg   <= {shreg[FW-2:0], 1'b0};  // next bit on falling sclk
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'd31) state <= IDLE;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign pop  = state == LOAD;
    assign sclk = (state == SHIFT) && (div_cnt >= DW'(DIV / 2));  // low half, then high half
    assign ws   = (state == SHIFT) && bit_cnt[4];                 // high for right word
    assign sd   = shreg[FW-1];

    // sd only moves while sclk is low
    assert property (@(posedge clk) disable iff (reset) $changed(sd) |-> !sclk);

endmodule

//--- hw/opl_top.sv
`timescale 1ns/10ps

module opl_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       cs,
    input  logic       rd,
    input  logic       wr,
    input  logic [7:0] address,
    input  logic [7:0] data_in,
    output logic [7:0] data_out,
    output logic       rd_valid,
    output logic       irq,
    output logic       sclk,
    output logic       ws,
    output logic       sd
);
    import opl_reg_pkg::*;
    import audio_pkg::*;

    voice_cfg_arr_t voice_cfg;
    timer_cfg_t     timer_cfg;
    stereo_frame_t  gen_frame;
    stereo_frame_t  head_frame;
    logic           enable;
    logic           ft1;
    logic           ft2;
    logic           sample_tick;
    logic           push;
    logic           pop;
    logic           full;
    logic           empty;

    reg_file reg_file_i (
        .clk       (clk),
        .reset     (reset),
        .cs        (cs),
        .rd        (rd),
        .wr        (wr),
        .address   (reg_addr_e'(address)),
        .data_in   (data_in),
        .ft1       (ft1),
        .ft2       (ft2),
        .irq       (irq),
        .data_out  (data_out),
        .rd_valid  (rd_valid),
        .voice_cfg (voice_cfg),
        .timer_cfg (timer_cfg),
        .enable    (enable)
    );

    timers timers_i (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .timer_cfg   (timer_cfg),
        .ft1         (ft1),
        .ft2         (ft2),
        .irq         (irq)
    );

    tone_gen tone_gen_i (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .voice_cfg   (voice_cfg),
        .full        (full),
        .sample_tick (sample_tick),
        .push        (push),
        .frame       (gen_frame)
    );

    frame_fifo frame_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .frame_in  (gen_frame),
        .pop       (pop),
        .frame_out (head_frame),
        .full      (full),
        .empty     (empty)
    );

    i2s_tx i2s_tx_i (
        .clk   (clk),
        .reset (reset),
        .empty (empty),
        .frame (head_frame),
        .pop   (pop),
        .sclk  (sclk),
        .ws    (ws),
        .sd    (sd)
    );

endmodule

//--- testbench/tb_opl_top.sv
`timescale 1ns/10ps
`include "opl_config.svh"

module tb_opl_top;
    import opl_reg_pkg::*;
    import audio_pkg::*;

    localparam int NV            = `OPL_NUM_VOICES;
    localparam int RD_TIMEOUT    = 16;
    localparam int BIT_TIMEOUT   = 4 * `OPL_SAMPLE_DIV;
    localparam int QUIET_CYCLES  = 64;
    localparam int QUIET_TIMEOUT = 8 * `OPL_SAMPLE_DIV;
    localparam int TIMER_TIMEOUT = 258 * `OPL_SAMPLE_DIV;  // full 8-bit wrap plus margin

    logic       clk;
    logic       reset;
    logic       cs;
    logic       rd;
    logic       wr;
    logic [7:0] address;
    logic [7:0] data_in;
    logic [7:0] data_out;
    logic       rd_valid;
    logic       irq;
    logic       sclk;
    logic       ws;
    logic       sd;

    logic [31:0] lfsr_state;
    voice_cfg_t  cfg [NV];       // model copy of the voice registers
    logic [7:0]  reg_model [20];  // writable registers 0x00..0x13

    opl_top opl_top_i (
        .clk      (clk),
        .reset    (reset),
        .cs       (cs),
        .rd       (rd),
        .wr       (wr),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .rd_valid (rd_valid),
        .irq      (irq),
        .sclk     (sclk),
        .ws       (ws),
        .sd       (sd)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    task automatic compare_frame(input string name, input stereo_frame_t exp,
                                 input stereo_frame_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp,
                                input logic [7:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // one clock, inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        cs      = 1'b1;
        wr      = 1'b1;
        address = addr;
        data_in = data;
        next_cycle();
        cs = 1'b0;
        wr = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
        int waited;
        cs      = 1'b1;
        rd      = 1'b1;
        address = addr;
        next_cycle();
        cs     = 1'b0;
        rd     = 1'b0;
        waited = 0;
        while (!rd_valid) begin
            next_cycle();
            waited++;
            if (!rd_valid && waited > RD_TIMEOUT) report_timeout("rd_valid after a read");
        end
        data = data_out;
    endtask

    task automatic write_all_voices();
        for (int v = 0; v < NV; v++) begin
            write_reg(8'(4 * v), cfg[v].fnum[7:0]);
            write_reg(8'(4 * v + 1), {2'b00, cfg[v].kon, cfg[v].block, cfg[v].fnum[9:8]});
            write_reg(8'(4 * v + 2), {4'h0, cfg[v].tl});
            write_reg(8'(4 * v + 3), {6'b0, cfg[v].cha, cfg[v].chb});
        end
    endtask

    // one burst of 32 bits, sd taken on each rising sclk
    task automatic capture_frame(input string name, output stereo_frame_t f);
        logic [31:0] bits;
        logic        prev;
        logic        rose;
        int          b;
        int          waited;
        bits = '0;
        for (b = 0; b < 32; b++) begin
            waited = 0;
            rose   = 1'b0;
            while (!rose) begin
                prev = sclk;
                next_cycle();
                waited++;
                rose = !prev && sclk;
                if (!rose && waited > BIT_TIMEOUT) report_timeout("a rising edge of sclk");
            end
            if (ws !== (b >= 16)) begin
                $display("ERR %s ws at bit %0d expected %b actual %b", name, b, b >= 16, ws);
                abort_run();
            end
            bits = {bits[30:0], sd};
        end
        f = bits;
    endtask

    task automatic wait_quiet();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < QUIET_CYCLES) begin
            next_cycle();
            waited++;
            quiet = sclk ? 0 : quiet + 1;
            if (waited > QUIET_TIMEOUT) report_timeout("the serial output to go idle");
        end
        compare_byte("serial idle ws and sd", 8'h00, {6'b0, ws, sd});
    endtask

    task automatic stop_and_drain();
        write_reg(REG_GLOBAL, 8'h00);
        wait_quiet();
    endtask

    function automatic sample_t clamp_sample(input int s);
        if (s > 32767) return 16'sh7fff;
        if (s < -32768) return 16'sh8000;
        return sample_t'(s);
    endfunction

    // frame expected for tick n after enable
    function automatic stereo_frame_t model_frame(input int n);
        stereo_frame_t f;
        int            step;
        int            ph;
        int            amp;
        int            sum_l;
        int            sum_r;
        sum_l = 0;
        sum_r = 0;
        for (int v = 0; v < NV; v++) begin
            step = int'(cfg[v].fnum) << cfg[v].block;
            ph   = (n * step) % (1 << 20);  // 20-bit accumulator
            amp  = cfg[v].kon ? (32767 >> cfg[v].tl) : 0;
            if (ph >= (1 << 19)) amp = -amp;
            if (cfg[v].cha) sum_l += amp;
            if (cfg[v].chb) sum_r += amp;
        end
        f.left  = clamp_sample(sum_l);
        f.right = clamp_sample(sum_r);
        return f;
    endfunction

    task automatic run_frames(input string name, input int count);
        stereo_frame_t got;
        int            n;
        write_reg(REG_GLOBAL, 8'h01);
        for (n = 1; n <= count; n++) begin
            capture_frame(name, got);
            compare_frame(name, model_frame(n), got);
        end
    endtask

    task automatic random_voice(input int v, input logic all_on, input int tl_bits);
        cfg[v].fnum  = 10'(lfsr_bits(10));
        cfg[v].block = 3'(lfsr_bits(3));
        cfg[v].tl    = 4'(lfsr_bits(tl_bits));
        cfg[v].kon   = all_on ? 1'b1 : 1'(lfsr_bits(1));
        cfg[v].cha   = all_on ? 1'b1 : 1'(lfsr_bits(1));
        cfg[v].chb   = 1'(lfsr_bits(1));
    endtask

    initial begin
        logic [7:0] rd_byte;
        logic [7:0] preload;
        int         addr;
        int         round;
        int         polls;
        clk        = 1'b0;
        reset      = 1'b1;
        cs         = 1'b0;
        rd         = 1'b0;
        wr         = 1'b0;
        address    = '0;
        data_in    = '0;
        lfsr_state = 32'd86508;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        for (addr = 0; addr < 20; addr++) begin
            reg_model[addr] = 8'(lfsr_bits(8));
            write_reg(8'(addr), reg_model[addr]);
        end
        for (addr = 0; addr < 20; addr++) begin
            read_reg(8'(addr), rd_byte);
            compare_byte("register readback", reg_model[addr], rd_byte);
        end
        repeat (8) begin
            addr = 8'h15 + int'(lfsr_bits(8)) % 235;  // anywhere above status
            read_reg(8'(addr), rd_byte);
            compare_byte("unmapped read", 8'h00, rd_byte);
        end

        stop_and_drain();
        for (int v = 0; v < NV; v++) cfg[v] = '0;
        random_voice(0, 1'b1, 2);
        cfg[0].chb = 1'b0;  // left only
        write_all_voices();
        run_frames("single voice", 40);

        for (round = 0; round < 3; round++) begin
            stop_and_drain();
            for (int v = 0; v < NV; v++) random_voice(v, 1'b1, 2);
            write_all_voices();
            run_frames("mix and clamp", 12);
        end

        for (round = 0; round < 3; round++) begin
            stop_and_drain();
            for (int v = 0; v < NV; v++) random_voice(v, 1'b0, 4);
            write_all_voices();
            run_frames("key-off and routing", 12);
        end

        write_reg(REG_TIMER_CTRL, 8'h80);
        preload = 8'(lfsr_bits(8));
        write_reg(REG_TIMER1, preload);
        write_reg(REG_GLOBAL, 8'h01);  // timers count on sample ticks
        write_reg(REG_TIMER_CTRL, 8'h02);
        polls = 0;
        while (!irq) begin
            next_cycle();
            polls++;
            if (!irq && polls > TIMER_TIMEOUT) report_timeout("irq from timer1");
        end
        read_reg(REG_STATUS, rd_byte);
        compare_byte("timer1 status", 8'hc0, rd_byte);
        write_reg(REG_TIMER_CTRL, 8'h80);
        next_cycle();  // flags clear one cycle after the write
        read_reg(REG_STATUS, rd_byte);
        compare_byte("status after irq_rst", 8'h00, rd_byte);

        preload = 8'(lfsr_bits(8));
        write_reg(REG_TIMER2, preload);
        write_reg(REG_TIMER_CTRL, 8'h21);  // mt2 and st2
        polls   = 0;
        rd_byte = '0;
        while (!rd_byte[5]) begin
            read_reg(REG_STATUS, rd_byte);
            compare_byte("masked timer irq", 8'h00, {7'b0, irq});
            polls++;
            if (!rd_byte[5] && polls > TIMER_TIMEOUT) report_timeout("ft2 in status");
        end
        compare_byte("masked timer status", 8'h20, rd_byte);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hw/opl_reg_pkg.sv
hw/audio_pkg.sv
hw/reg_file.sv
hw/timers.sv
hw/tone_gen.sv
hw/frame_fifo.sv
hw/i2s_tx.sv
hw/opl_top.sv
testbench/tb_opl_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_opl_top -o tb_opl_top > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
{ ./obj_dir/tb_opl_top > sim.log 2>&1 || true; }
cat sim.log
grep -q "^NO ERRORS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
